//--- include/bbc_glue_settings.svh
`ifndef BBC_GLUE_SETTINGS_SVH
`define BBC_GLUE_SETTINGS_SVH

// Master clock cycles per 2 MHz CPU cycle
`define BBC_CPU_DIV 24

// First phase count with phi0 high
`define BBC_PHI0_HIGH 12

// SHEILA control registers
`define BBC_SHEILA_PAGE 8'hFE
`define BBC_ADDR_ROMSEL 16'hFE30
`define BBC_ADDR_ACCCON 16'hFE34
`define BBC_ADDR_FDCON 16'hFE24

// Wrap adders applied to MA[11:8] when MA bit 12 is set
// Mode 3 restarts at 0x4000
`define BBC_WRAP_MODE3 4'd8
// Mode 6 restarts at 0x6000
`define BBC_WRAP_MODE6 4'd12
// Modes 0, 1 and 2 restart at 0x3000
`define BBC_WRAP_MODE012 4'd6
// Modes 4 and 5 restart at 0x5800
`define BBC_WRAP_MODE45 4'd11

// Top address bits of the VDU driver region C000-DFFF
`define BBC_VDU_REGION 3'b110

`endif

//--- logic/bbc_glue_pkg.sv
package bbc_glue_pkg;

	// Data bus byte
	typedef logic [7:0] byte_t;

	// CPU and memory address
	typedef logic [15:0] cpu_addr_t;

	// Screen RAM address after wrap compensation
	typedef logic [14:0] disp_addr_t;

	// CRTC refresh address and raster row
	typedef logic [13:0] crtc_ma_t;
	typedef logic [4:0] crtc_ra_t;

	// Screen size class from IC32 bits 5:4
	typedef logic [1:0] wrap_sel_t;

	// One-hot low drive select to the floppy controller
	typedef logic [3:0] drive_sel_t;

endpackage

//--- logic/clock_enables.sv
`timescale 1ns/1ps
`include "bbc_glue_settings.svh"

module clock_enables (
	input  logic CLK48M_I,
	input  logic reset_n,
	output logic cpu_clken_o,
	output logic phi0_o
);

	logic [4:0] phase;
	logic [4:0] phase_nxt;

	// Wraps after 24 master cycles for a 2 MHz CPU
	assign phase_nxt = (phase == 5'(`BBC_CPU_DIV - 1)) ? 5'd0 : phase + 5'd1;

	// Outputs are registered from the next phase so they line up with it
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			phase <= 5'd0;
			phi0_o <= 1'b0;
			cpu_clken_o <= 1'b0;
		end else begin
			phase <= phase_nxt;
			phi0_o <= (phase_nxt >= 5'(`BBC_PHI0_HIGH));
			cpu_clken_o <= (phase_nxt == 5'(`BBC_CPU_DIV - 1));
		end
	end

	// CPU cycle ends in the last CPU half of the bus cycle
	a_clken_in_phi0: assert property (@(posedge CLK48M_I) disable iff (!reset_n)
		cpu_clken_o |-> phi0_o);

endmodule

//--- logic/sheila_regs.sv
`timescale 1ns/1ps
`include "bbc_glue_settings.svh"

module sheila_regs import bbc_glue_pkg::*; (
	input  logic       CLK48M_I,
	input  logic       reset_n,
	input  logic       model_i,
	input  logic       cpu_clken_i,
	input  cpu_addr_t  cpu_a_i,
	input  byte_t      cpu_do_i,
	input  logic       cpu_r_nw_i,
	input  byte_t      mem_di_i,
	output byte_t      cpu_di_o,
	output byte_t      romsel_o,
	output byte_t      acccon_o,
	output drive_sel_t floppy_drive_o,
	output logic       floppy_side_o,
	output logic       floppy_reset_o
);

	logic io_sheila;
	logic wr_cycle;

	assign io_sheila = (cpu_a_i[15:8] == `BBC_SHEILA_PAGE);
	assign wr_cycle = cpu_clken_i & ~cpu_r_nw_i;

	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			romsel_o <= '0;
			acccon_o <= '0;
			floppy_drive_o <= 4'b1111;
			floppy_side_o <= 1'b0;
			floppy_reset_o <= 1'b0;
		end else if (wr_cycle) begin
			// Model B has only 16 ROM slots, no RAM select bit
			if (cpu_a_i == `BBC_ADDR_ROMSEL)
				romsel_o <= {cpu_do_i[7] & model_i, cpu_do_i[6:0]};
			if (cpu_a_i == `BBC_ADDR_ACCCON)
				acccon_o <= cpu_do_i;
			// Drive control: drive 0/1 select, reset and inverted side
			if (cpu_a_i == `BBC_ADDR_FDCON) begin
				floppy_drive_o <= {3'b111, ~cpu_do_i[0]};
				floppy_reset_o <= cpu_do_i[2];
				floppy_side_o <= ~cpu_do_i[4];
			end
		end
	end

	// Undecoded SHEILA locations read as zero
	always_comb begin
		if (!io_sheila)
			cpu_di_o = mem_di_i;
		else if (cpu_a_i == `BBC_ADDR_ACCCON)
			cpu_di_o = acccon_o;
		else if (cpu_a_i == `BBC_ADDR_ROMSEL)
			cpu_di_o = model_i ? romsel_o : '0;
		else
			cpu_di_o = '0;
	end

	// The Model B never holds the RAM bit
	a_romsel_b7: assert property (@(posedge CLK48M_I) disable iff (!reset_n)
		!model_i |-> !romsel_o[7]);

endmodule

//--- logic/ic32_latch.sv
`timescale 1ns/1ps

module ic32_latch import bbc_glue_pkg::*; (
	input  logic      CLK48M_I,
	input  logic      reset_n,
	input  byte_t     sys_via_pb_i,
	output wrap_sel_t wrap_sel_o,
	output logic      sound_enable_n_o,
	output logic      keyb_enable_n_o,
	output logic      caps_led_n_o,
	output logic      shift_led_n_o
);

	byte_t ic32;

	// PB2..0 pick the bit, PB3 is the value written
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n)
			ic32 <= '0;
		else
			ic32[sys_via_pb_i[2:0]] <= sys_via_pb_i[3];
	end

	// Bits 1 and 2 are speech strobes, not fitted here
	assign sound_enable_n_o = ic32[0];
	assign keyb_enable_n_o = ic32[3];
	assign wrap_sel_o = ic32[5:4];
	assign caps_led_n_o = ic32[6];
	assign shift_led_n_o = ic32[7];

endmodule

//--- logic/display_addr.sv
`timescale 1ns/1ps
`include "bbc_glue_settings.svh"

module display_addr import bbc_glue_pkg::*; (
	input  crtc_ma_t   crtc_ma_i,
	input  crtc_ra_t   crtc_ra_i,
	input  wrap_sel_t  wrap_sel_i,
	output disp_addr_t disp_a_o
);

	logic [3:0] page_adj;
	logic [3:0] wrap_add;

	// Adder brings the screen back into RAM past 0x8000
	always_comb begin
		case (wrap_sel_i)
			2'b00: wrap_add = `BBC_WRAP_MODE3;
			2'b01: wrap_add = `BBC_WRAP_MODE6;
			2'b10: wrap_add = `BBC_WRAP_MODE012;
			default: wrap_add = `BBC_WRAP_MODE45;
		endcase
	end

	// Sum is modulo 16 by width
	assign page_adj = crtc_ma_i[12] ? (crtc_ma_i[11:8] + wrap_add) : crtc_ma_i[11:8];

	// Teletext reads 1K at 0x7C00, graphics modes use 8 rows per character
	assign disp_a_o = crtc_ma_i[13] ?
		{page_adj[3], 4'b1111, crtc_ma_i[9:0]} :
		{page_adj, crtc_ma_i[7:0], crtc_ra_i[2:0]};

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps
`include "bbc_glue_settings.svh"

module mem_arbiter import bbc_glue_pkg::*; (
	input  logic       CLK48M_I,
	input  logic       reset_n,
	input  logic       cpu_clken_i,
	input  logic       phi0_i,
	input  cpu_addr_t  cpu_a_i,
	input  logic       cpu_r_nw_i,
	input  logic       cpu_sync_i,
	input  disp_addr_t disp_a_i,
	input  byte_t      acccon_i,
	input  logic       sys_via_irq_i,
	input  logic       user_via_irq_i,
	input  logic       fdc_irq_i,
	input  logic       fdc_drq_i,
	output cpu_addr_t  mem_adr_o,
	output logic       mem_we_o,
	output logic       shadow_ram_o,
	output logic       irq_n_o,
	output logic       nmi_n_o
);

	logic vdu_op;
	logic in_shadow;

	// CPU owns RAM in phi0 high, video fetches in the other half
	assign mem_adr_o = phi0_i ? cpu_a_i : {1'b0, disp_a_i};
	assign mem_we_o = phi0_i & ~cpu_r_nw_i;

	// Last opcode fetch came from the VDU driver area
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n)
			vdu_op <= 1'b0;
		else if (cpu_clken_i && cpu_sync_i)
			vdu_op <= (cpu_a_i[15:13] == `BBC_VDU_REGION);
	end

	// Shadow window 3000-7FFF
	assign in_shadow = (cpu_a_i[15:12] == 4'h3) || (cpu_a_i[15:14] == 2'b01);
	assign shadow_ram_o = in_shadow &&
		(acccon_i[2] || (acccon_i[1] && vdu_op && !cpu_sync_i));

	assign irq_n_o = ~(sys_via_irq_i | user_via_irq_i | acccon_i[7]);
	assign nmi_n_o = ~(fdc_irq_i | fdc_drq_i);

	a_we_in_phi0: assert property (@(posedge CLK48M_I) disable iff (!reset_n)
		mem_we_o |-> phi0_i);

endmodule

//--- logic/bbc_glue_top.sv
`timescale 1ns/1ps

module bbc_glue_top import bbc_glue_pkg::*; (
	input  logic       CLK48M_I,
	input  logic       reset_n,
	input  logic       model_i,
	input  cpu_addr_t  cpu_a_i,
	input  byte_t      cpu_do_i,
	input  logic       cpu_r_nw_i,
	input  logic       cpu_sync_i,
	input  byte_t      mem_di_i,
	input  byte_t      sys_via_pb_i,
	input  logic       sys_via_irq_i,
	input  logic       user_via_irq_i,
	input  logic       fdc_irq_i,
	input  logic       fdc_drq_i,
	input  crtc_ma_t   crtc_ma_i,
	input  crtc_ra_t   crtc_ra_i,
	output logic       cpu_clken_o,
	output logic       phi0_o,
	output byte_t      cpu_di_o,
	output byte_t      romsel_o,
	output logic       acc_y_o,
	output logic       shadow_vid_o,
	output logic       shadow_ram_o,
	output cpu_addr_t  mem_adr_o,
	output logic       mem_we_o,
	output logic       irq_n_o,
	output logic       nmi_n_o,
	output drive_sel_t floppy_drive_o,
	output logic       floppy_side_o,
	output logic       floppy_reset_o,
	output logic       sound_enable_n_o,
	output logic       keyb_enable_n_o,
	output logic       caps_led_n_o,
	output logic       shift_led_n_o
);

	byte_t      acccon;
	wrap_sel_t  wrap_sel;
	disp_addr_t disp_a;

	// Y selects the HAZEL overlay, D the shadow screen
	assign acc_y_o = acccon[3];
	assign shadow_vid_o = acccon[0];

	clock_enables u_clock_enables (
		.CLK48M_I    (CLK48M_I),
		.reset_n     (reset_n),
		.cpu_clken_o (cpu_clken_o),
		.phi0_o      (phi0_o)
	);

	sheila_regs u_sheila_regs (
		.CLK48M_I       (CLK48M_I),
		.reset_n        (reset_n),
		.model_i        (model_i),
		.cpu_clken_i    (cpu_clken_o),
		.cpu_a_i        (cpu_a_i),
		.cpu_do_i       (cpu_do_i),
		.cpu_r_nw_i     (cpu_r_nw_i),
		.mem_di_i       (mem_di_i),
		.cpu_di_o       (cpu_di_o),
		.romsel_o       (romsel_o),
		.acccon_o       (acccon),
		.floppy_drive_o (floppy_drive_o),
		.floppy_side_o  (floppy_side_o),
		.floppy_reset_o (floppy_reset_o)
	);

	ic32_latch u_ic32_latch (
		.CLK48M_I         (CLK48M_I),
		.reset_n          (reset_n),
		.sys_via_pb_i     (sys_via_pb_i),
		.wrap_sel_o       (wrap_sel),
		.sound_enable_n_o (sound_enable_n_o),
		.keyb_enable_n_o  (keyb_enable_n_o),
		.caps_led_n_o     (caps_led_n_o),
		.shift_led_n_o    (shift_led_n_o)
	);

	display_addr u_display_addr (
		.crtc_ma_i  (crtc_ma_i),
		.crtc_ra_i  (crtc_ra_i),
		.wrap_sel_i (wrap_sel),
		.disp_a_o   (disp_a)
	);

	mem_arbiter u_mem_arbiter (
		.CLK48M_I       (CLK48M_I),
		.reset_n        (reset_n),
		.cpu_clken_i    (cpu_clken_o),
		.phi0_i         (phi0_o),
		.cpu_a_i        (cpu_a_i),
		.cpu_r_nw_i     (cpu_r_nw_i),
		.cpu_sync_i     (cpu_sync_i),
		.disp_a_i       (disp_a),
		.acccon_i       (acccon),
		.sys_via_irq_i  (sys_via_irq_i),
		.user_via_irq_i (user_via_irq_i),
		.fdc_irq_i      (fdc_irq_i),
		.fdc_drq_i      (fdc_drq_i),
		.mem_adr_o      (mem_adr_o),
		.mem_we_o       (mem_we_o),
		.shadow_ram_o   (shadow_ram_o),
		.irq_n_o        (irq_n_o),
		.nmi_n_o        (nmi_n_o)
	);

endmodule

//--- verification/tb_bbc_glue.sv
`timescale 1ns/1ps

module tb_bbc_glue import bbc_glue_pkg::*;;

	logic CLK48M_I;
	logic reset_n;
	logic model_i, cpu_r_nw_i, cpu_sync_i;
	cpu_addr_t cpu_a_i;
	byte_t cpu_do_i, mem_di_i, sys_via_pb_i;
	logic sys_via_irq_i, user_via_irq_i, fdc_irq_i, fdc_drq_i;
	crtc_ma_t crtc_ma_i;
	crtc_ra_t crtc_ra_i;
	logic cpu_clken_o, phi0_o, acc_y_o, shadow_vid_o, shadow_ram_o, mem_we_o;
	logic irq_n_o, nmi_n_o, floppy_side_o, floppy_reset_o;
	logic sound_enable_n_o, keyb_enable_n_o, caps_led_n_o, shift_led_n_o;
	byte_t cpu_di_o, romsel_o;
	cpu_addr_t mem_adr_o;
	drive_sel_t floppy_drive_o;

	// Reference model state
	int cnt;
	logic m_clken, m_phi0, m_vdu, m_side, m_fres;
	byte_t m_romsel, m_acccon, m_ic32;
	logic [3:0] m_drive;
	logic [15:0] lfsr;
	int value_errors;
	int timeout_errors;

	bbc_glue_top u_dut (.*);

	initial begin
		CLK48M_I = 1'b0;
		forever #50 CLK48M_I = ~CLK48M_I;
	end

	// Galois LFSR, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [14:0] expect_disp(input logic [13:0] ma, input logic [4:0] ra,
		input logic [1:0] ws);
		logic [3:0] add;
		logic [3:0] nib;
		add = (ws == 2'd0) ? 4'd8 : (ws == 2'd1) ? 4'd12 : (ws == 2'd2) ? 4'd6 : 4'd11;
		nib = ma[12] ? ma[11:8] + add : ma[11:8];
		if (ma[13])
			return {nib[3], 4'b1111, ma[9:0]};
		return {nib, ma[7:0], ra[2:0]};
	endfunction

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (exp === act) else begin
			value_errors++;
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// Model follows the bus on the same edges as the hardware
	always @(posedge CLK48M_I) begin
		if (!reset_n) begin
			cnt = 0;
			m_clken = 0;
			m_phi0 = 0;
			m_vdu = 0;
			m_romsel = '0;
			m_acccon = '0;
			m_ic32 = '0;
			m_drive = 4'b1111;
			m_side = 0;
			m_fres = 0;
		end else begin
			if (m_clken && !cpu_r_nw_i) begin
				if (cpu_a_i == 16'hFE30)
					m_romsel = {cpu_do_i[7] & model_i, cpu_do_i[6:0]};
				if (cpu_a_i == 16'hFE34)
					m_acccon = cpu_do_i;
				if (cpu_a_i == 16'hFE24) begin
					m_drive = {3'b111, ~cpu_do_i[0]};
					m_fres = cpu_do_i[2];
					m_side = ~cpu_do_i[4];
				end
			end
			if (m_clken && cpu_sync_i)
				m_vdu = (cpu_a_i[15:13] == 3'b110);
			m_ic32[sys_via_pb_i[2:0]] = sys_via_pb_i[3];
			cnt = (cnt == 23) ? 0 : cnt + 1;
			m_clken = (cnt == 23);
			m_phi0 = (cnt >= 12);
		end
	end

	always @(negedge CLK48M_I) begin : check_outputs
		logic [15:0] e_di;
		logic e_shadow;
		if (reset_n) begin
			if (cpu_a_i[15:8] != 8'hFE)
				e_di = {8'h00, mem_di_i};
			else if (cpu_a_i == 16'hFE34)
				e_di = {8'h00, m_acccon};
			else if (cpu_a_i == 16'hFE30 && model_i)
				e_di = {8'h00, m_romsel};
			else
				e_di = '0;
			e_shadow = (cpu_a_i >= 16'h3000 && cpu_a_i <= 16'h7FFF) &&
				(m_acccon[2] || (m_acccon[1] && m_vdu && !cpu_sync_i));
			check_val("cpu_clken_o", {15'd0, m_clken}, {15'd0, cpu_clken_o});
			check_val("phi0_o", {15'd0, m_phi0}, {15'd0, phi0_o});
			check_val("cpu_di_o", e_di, {8'h00, cpu_di_o});
			check_val("romsel_o", {8'h00, m_romsel}, {8'h00, romsel_o});
			check_val("acc_y_o", {15'd0, m_acccon[3]}, {15'd0, acc_y_o});
			check_val("shadow_vid_o", {15'd0, m_acccon[0]}, {15'd0, shadow_vid_o});
			check_val("mem_adr_o", m_phi0 ? cpu_a_i : {1'b0, expect_disp(crtc_ma_i,
				crtc_ra_i, m_ic32[5:4])}, mem_adr_o);
			check_val("mem_we_o", {15'd0, m_phi0 & ~cpu_r_nw_i}, {15'd0, mem_we_o});
			check_val("shadow_ram_o", {15'd0, e_shadow}, {15'd0, shadow_ram_o});
			check_val("irq_n_o", {15'd0, ~(sys_via_irq_i | user_via_irq_i | m_acccon[7])},
				{15'd0, irq_n_o});
			check_val("nmi_n_o", {15'd0, ~(fdc_irq_i | fdc_drq_i)}, {15'd0, nmi_n_o});
			check_val("floppy", {10'd0, m_drive, m_side, m_fres},
				{10'd0, floppy_drive_o, floppy_side_o, floppy_reset_o});
			check_val("ic32", {12'd0, m_ic32[7:6], m_ic32[3], m_ic32[0]},
				{12'd0, shift_led_n_o, caps_led_n_o, keyb_enable_n_o, sound_enable_n_o});
		end
	end

	// Returns on the edge at which the CPU cycle ends
	task automatic wait_clken();
		int i;
		for (i = 0; i < 60; i++) begin
			@(posedge CLK48M_I);
			if (cpu_clken_o)
				return;
		end
		timeout_errors++;
		$display("Timeout while waiting for the CPU clock enable");
	endtask

	task automatic wait_phi0_low();
		int i;
		for (i = 0; i < 60; i++) begin
			@(posedge CLK48M_I);
			if (!phi0_o)
				return;
		end
		timeout_errors++;
		$display("Timeout while waiting for phi0 to go low");
	endtask

	task automatic bus_write(input logic [15:0] addr, input byte_t data);
		cpu_a_i <= addr;
		cpu_do_i <= data;
		cpu_r_nw_i <= 1'b0;
		wait_clken();
		cpu_r_nw_i <= 1'b1;
	endtask

	task automatic bus_read(input logic [15:0] addr);
		cpu_a_i <= addr;
		cpu_r_nw_i <= 1'b1;
		mem_di_i <= byte_t'(rand_bits(8));
		wait_clken();
	endtask

	initial begin
		logic [15:0] a;
		lfsr = 16'd63298;
		value_errors = 0;
		timeout_errors = 0;
		reset_n = 1'b0;
		model_i = 1'b1;
		cpu_r_nw_i = 1'b1;
		cpu_sync_i = 1'b0;
		cpu_a_i = '0;
		cpu_do_i = '0;
		mem_di_i = '0;
		sys_via_pb_i = '0;
		sys_via_irq_i = 1'b0;
		user_via_irq_i = 1'b0;
		fdc_irq_i = 1'b0;
		fdc_drq_i = 1'b0;
		crtc_ma_i = '0;
		crtc_ra_i = '0;
		repeat (16) @(posedge CLK48M_I);
		reset_n <= 1'b1;
		wait_clken();
		wait_clken();
		// ROMSEL and read multiplexer on both models
		for (int m = 1; m >= 0; m--) begin
			// Model B strap only with the RAM bit clear
			if (!m[0])
				bus_write(16'hFE30, 8'h00);
			model_i <= m[0];
			for (int k = 0; k < 4; k++) begin
				bus_write(16'hFE30, byte_t'(rand_bits(8)));
				bus_read(16'hFE30);
				a = rand_bits(16);
				bus_read((a[15:8] == 8'hFE) ? {8'h12, a[7:0]} : a);
				bus_read(16'hFE10);
			end
		end
		// ACCCON and interrupt combine
		bus_write(16'hFE34, byte_t'(rand_bits(8)) | 8'h09);
		bus_read(16'hFE34);
		bus_write(16'hFE34, 8'h80);
		bus_write(16'hFE34, 8'h00);
		sys_via_irq_i <= 1'b1;
		wait_clken();
		sys_via_irq_i <= 1'b0;
		user_via_irq_i <= 1'b1;
		fdc_irq_i <= 1'b1;
		wait_clken();
		user_via_irq_i <= 1'b0;
		fdc_irq_i <= 1'b0;
		fdc_drq_i <= 1'b1;
		wait_clken();
		fdc_drq_i <= 1'b0;
		// IC32 bits, then display translation for each wrap select
		for (int b = 0; b < 8; b++) begin
			@(posedge CLK48M_I);
			sys_via_pb_i <= {4'h0, rand_bits(1) == 16'd1, 3'(b)};
		end
		for (int w = 0; w < 4; w++) begin
			@(posedge CLK48M_I);
			sys_via_pb_i <= {4'h0, w[0], 3'd4};
			@(posedge CLK48M_I);
			sys_via_pb_i <= {4'h0, w[1], 3'd5};
			for (int k = 0; k < 6; k++) begin
				wait_phi0_low();
				crtc_ma_i <= crtc_ma_t'(rand_bits(14));
				crtc_ra_i <= crtc_ra_t'(rand_bits(5));
				repeat (3) @(posedge CLK48M_I);
			end
		end
		// Shadow RAM by X bit, then by E bit after a VDU fetch
		bus_write(16'hFE34, 8'h04);
		bus_read(16'h3000 + rand_bits(14));
		bus_write(16'hFE34, 8'h02);
		cpu_sync_i <= 1'b1;
		bus_read(16'hC123);
		cpu_sync_i <= 1'b0;
		bus_write(16'h5000 + rand_bits(12), byte_t'(rand_bits(8)));
		bus_read(16'h7FFF);
		cpu_sync_i <= 1'b1;
		bus_read(16'h8100);
		cpu_sync_i <= 1'b0;
		bus_read(16'h4000);
		for (int k = 0; k < 3; k++)
			bus_write(16'hFE24, byte_t'(rand_bits(8)));
		wait_clken();
		$display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- bbc_glue.f
+incdir+include
logic/bbc_glue_pkg.sv
logic/clock_enables.sv
logic/sheila_regs.sv
logic/ic32_latch.sv
logic/display_addr.sv
logic/mem_arbiter.sv
logic/bbc_glue_top.sv
verification/tb_bbc_glue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, run from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f bbc_glue.f --top-module tb_bbc_glue -o tb_bbc_glue
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_bbc_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
exit 0
